//--- rtl/usb_in_pkg.sv
package usb_in_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [3:0] endpt_t;

  // One beat as held by the skid buffer
  typedef struct packed {
    logic  keep;
    byte_t data;
  } in_beat_t;

  // Per-frame telemetry byte
  typedef struct packed {
    logic [3:0] seq;       // SOF sequence number
    logic [3:0] crc_errs;  // Saturating CRC-error count
  } tele_rec_t;

  localparam int TELE_ENDPOINT_DEF = 2;
  localparam int TELE_DEPTH_DEF    = 64;
  localparam int TELE_MAX_PKT_DEF  = 32;

  // Fill-level thresholds
  localparam int IN_READY_LEVEL = 16;
  localparam int HAS_TELE_LEVEL = 4;

endpackage

//--- rtl/in_stream_if.sv
`timescale 1ns/1ps

// Byte stream with AXI-style valid/ready handshake
interface in_stream_if;

  logic                valid;
  logic                ready;
  logic                last;
  logic                keep;
  usb_in_pkg::byte_t   data;

  modport source (
    output valid,
    output last,
    output keep,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  keep,
    input  data,
    output ready
  );

endinterface

//--- rtl/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
  input  logic clock,
  input  logic areset_n,
  input  logic usb_reset_i,
  output logic reset_no,
  output logic core_reset_o
);

  logic [3:0] stage_q;

  // Ones shift in after the async reset lets go
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      stage_q <= 4'b0000;
    end else begin
      stage_q[0] <= 1'b1;
      stage_q[1] <= stage_q[0];
      // Bus reset pulls back the top two stages, so the core
      // comes out two cycles after the bus reset ends
      stage_q[2] <= stage_q[1] & ~usb_reset_i;
      stage_q[3] <= stage_q[2] & ~usb_reset_i;
    end
  end

  assign reset_no     = stage_q[1];   // PHY reset release
  assign core_reset_o = ~stage_q[3];  // Synchronous clear for the core

endmodule

//--- rtl/tele_fifo.sv
`timescale 1ns/1ps

module tele_fifo #(
  parameter  int tele_depth = usb_in_pkg::TELE_DEPTH_DEF,
  localparam int level_w    = $clog2(tele_depth + 1)
) (
  input  logic                    clock,
  input  logic                    areset_n,
  input  logic                    clear_i,
  input  logic                    push_i,
  input  usb_in_pkg::tele_rec_t   push_data_i,
  input  logic                    pop_i,
  output usb_in_pkg::byte_t       pop_data_o,
  output logic [level_w-1:0]      level_o
);

  localparam int addr_w = (tele_depth > 1) ? $clog2(tele_depth) : 1;

  usb_in_pkg::byte_t mem [tele_depth];

  logic [addr_w-1:0] wr_ptr_q;
  logic [addr_w-1:0] rd_ptr_q;
  logic              do_push;
  logic              do_pop;

  assign do_push = push_i && (level_o != level_w'(tele_depth));  // Dropped when full
  assign do_pop  = pop_i && (level_o != '0);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_o  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_o  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == addr_w'(tele_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == addr_w'(tele_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      level_o <= level_o + level_w'(do_push) - level_w'(do_pop);
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr_q] <= usb_in_pkg::byte_t'(push_data_i);
    end
  end

  assign pop_data_o = mem[rd_ptr_q];  // Head of queue, read ahead

endmodule

//--- rtl/telemetry_recorder.sv
`timescale 1ns/1ps

module telemetry_recorder #(
  parameter  int tele_depth   = usb_in_pkg::TELE_DEPTH_DEF,
  parameter  int tele_max_pkt = usb_in_pkg::TELE_MAX_PKT_DEF,
  localparam int level_w      = $clog2(tele_depth + 1)
) (
  input  logic               clock,
  input  logic               areset_n,
  input  logic               clear_i,
  input  logic               usb_sof_i,
  input  logic               crc_err_i,
  input  logic               tele_start_i,
  output logic [level_w-1:0] level_o,
  in_stream_if.source        tele_o
);

  // Packet can never be longer than the FIFO holds
  localparam int pkt_cap = (tele_max_pkt < tele_depth) ? tele_max_pkt : tele_depth;
  localparam logic [level_w-1:0] pkt_cap_l = level_w'(pkt_cap);

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_send
  } state_t;

  state_t                state_q;
  logic [level_w-1:0]    len_q;     // Bytes left in the packet
  logic [3:0]            seq_q;
  logic [3:0]            crc_cnt_q;
  logic [3:0]            crc_cnt_w;
  usb_in_pkg::tele_rec_t rec_w;
  logic                  pop_w;

  // An error in the SOF cycle still counts for the closing frame
  assign crc_cnt_w = (crc_err_i && crc_cnt_q != 4'hf) ? crc_cnt_q + 4'd1 : crc_cnt_q;
  assign rec_w     = '{seq: seq_q, crc_errs: crc_cnt_w};

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      seq_q     <= '0;
      crc_cnt_q <= '0;
    end else if (clear_i) begin
      seq_q     <= '0;
      crc_cnt_q <= '0;
    end else if (usb_sof_i) begin
      seq_q     <= seq_q + 4'd1;
      crc_cnt_q <= '0;
    end else begin
      crc_cnt_q <= crc_cnt_w;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q <= st_idle;
      len_q   <= '0;
    end else if (clear_i) begin
      state_q <= st_idle;
      len_q   <= '0;
    end else begin
      case (state_q)
        st_idle: if (tele_start_i) begin
          len_q   <= (level_o > pkt_cap_l) ? pkt_cap_l : level_o;
          state_q <= st_load;
        end
        st_load: state_q <= (len_q != '0) ? st_send : st_idle;  // Empty read sends nothing
        st_send: if (pop_w) begin
          len_q <= len_q - 1'b1;
          if (len_q == level_w'(1)) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign pop_w = (state_q == st_send) && tele_o.ready;

  assign tele_o.valid = (state_q == st_send);
  assign tele_o.last  = (len_q == level_w'(1));
  assign tele_o.keep  = 1'b1;

  tele_fifo #(
    .tele_depth (tele_depth)
  ) u_fifo (
    .clock       (clock),
    .areset_n    (areset_n),
    .clear_i     (clear_i),
    .push_i      (usb_sof_i),
    .push_data_i (rec_w),
    .pop_i       (pop_w),
    .pop_data_o  (tele_o.data),
    .level_o     (level_o)
  );

endmodule

//--- rtl/in_stream_select.sv
`timescale 1ns/1ps

module in_stream_select #(
  parameter int tele_endpoint = usb_in_pkg::TELE_ENDPOINT_DEF,
  parameter int level_w       = 7
) (
  input  logic               clock,
  input  logic               areset_n,
  input  logic               clear_i,
  input  usb_in_pkg::endpt_t blk_endpt_i,
  input  logic               blk_start_i,
  input  logic               blk_in_ready_i,
  input  logic [level_w-1:0] tele_level_i,
  input  logic               s_valid_i,
  input  logic               s_last_i,
  input  logic               s_keep_i,
  input  usb_in_pkg::byte_t  s_data_i,
  output logic               s_ready_o,
  in_stream_if.sink          tele_i,
  in_stream_if.source        mux_o,
  output logic               tele_start_o,
  output logic               blk_in_ready_o,
  output logic               has_telemetry_o
);

  logic tele_hit;
  logic tele_sel_q;

  assign tele_hit = (blk_endpt_i == usb_in_pkg::endpt_t'(tele_endpoint));

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      tele_sel_q     <= 1'b0;
      blk_in_ready_o <= 1'b0;
    end else if (clear_i) begin
      tele_sel_q     <= 1'b0;
      blk_in_ready_o <= 1'b0;
    end else begin
      tele_sel_q     <= tele_hit;
      // Enough telemetry queued counts as data ready too
      blk_in_ready_o <= blk_in_ready_i || (tele_level_i >= usb_in_pkg::IN_READY_LEVEL);
    end
  end

  assign tele_start_o    = blk_start_i && tele_hit;
  assign has_telemetry_o = (tele_level_i >= usb_in_pkg::HAS_TELE_LEVEL);

  // 2:1 stream mux
  assign mux_o.valid = tele_sel_q ? tele_i.valid : s_valid_i;
  assign mux_o.last  = tele_sel_q ? tele_i.last  : s_last_i;
  assign mux_o.keep  = tele_sel_q ? tele_i.keep  : s_keep_i;
  assign mux_o.data  = tele_sel_q ? tele_i.data  : s_data_i;

  // Ready only reaches the selected source
  assign tele_i.ready = tele_sel_q & mux_o.ready;
  assign s_ready_o    = ~tele_sel_q & mux_o.ready;

endmodule

//--- rtl/axis_skid.sv
`timescale 1ns/1ps

module axis_skid #(
  parameter type payload_t = usb_in_pkg::in_beat_t
) (
  input  logic      clock,
  input  logic      areset_n,
  input  logic      clear_i,
  in_stream_if.sink s_i,
  output logic      m_valid_o,
  input  logic      m_ready_i,
  output logic      m_last_o,
  output payload_t  m_payload_o
);

  usb_in_pkg::in_beat_t in_beat;
  payload_t             in_payload;
  payload_t             spare_q;
  logic                 spare_last_q;
  logic                 spare_valid_q;
  logic                 in_xfer;
  logic                 load_out;

  assign in_beat    = '{keep: s_i.keep, data: s_i.data};
  assign in_payload = payload_t'(in_beat);

  assign s_i.ready = ~spare_valid_q;  // Registered, drops once the spare is used
  assign in_xfer   = s_i.valid & ~spare_valid_q;
  assign load_out  = ~m_valid_o | m_ready_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      m_valid_o     <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (clear_i) begin
      m_valid_o     <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (load_out) begin
      m_valid_o     <= spare_valid_q | in_xfer;
      spare_valid_q <= 1'b0;
    end else if (in_xfer) begin
      spare_valid_q <= 1'b1;  // Output stalled, park the beat
    end
  end

  always_ff @(posedge clock) begin
    if (load_out) begin
      // Spare is older than anything on the input
      m_payload_o <= spare_valid_q ? spare_q : in_payload;
      m_last_o    <= spare_valid_q ? spare_last_q : s_i.last;
    end else if (in_xfer) begin
      spare_q      <= in_payload;
      spare_last_q <= s_i.last;
    end
  end

endmodule

//--- rtl/usb_bulk_in_top.sv
`timescale 1ns/1ps

module usb_bulk_in_top #(
  parameter int tele_endpoint = usb_in_pkg::TELE_ENDPOINT_DEF,
  parameter int tele_depth    = usb_in_pkg::TELE_DEPTH_DEF,
  parameter int tele_max_pkt  = usb_in_pkg::TELE_MAX_PKT_DEF
) (
  input  logic               clock,
  input  logic               areset_n,
  input  logic               usb_reset_i,
  input  logic               usb_sof_i,
  input  logic               crc_err_i,
  input  logic               blk_start_i,
  input  logic               blk_in_ready_i,
  input  usb_in_pkg::endpt_t blk_endpt_i,
  input  logic               s_axis_tvalid_i,
  input  logic               s_axis_tlast_i,
  input  logic               s_axis_tkeep_i,
  input  usb_in_pkg::byte_t  s_axis_tdata_i,
  output logic               s_axis_tready_o,
  output logic               m_axis_tvalid_o,
  output logic               m_axis_tlast_o,
  output logic               m_axis_tkeep_o,
  output usb_in_pkg::byte_t  m_axis_tdata_o,
  input  logic               m_axis_tready_i,
  output logic               reset_no,
  output logic               usb_reset_o,
  output logic               blk_in_ready_o,
  output logic               has_telemetry_o
);

  localparam int level_w = $clog2(tele_depth + 1);

  logic                 core_reset;
  logic                 tele_start;
  logic [level_w-1:0]   tele_level;
  usb_in_pkg::in_beat_t m_beat;

  in_stream_if tele_stream ();
  in_stream_if mux_stream ();

  assign usb_reset_o    = core_reset;
  assign m_axis_tkeep_o = m_beat.keep;
  assign m_axis_tdata_o = m_beat.data;

  reset_sequencer u_reset_seq (
    .clock        (clock),
    .areset_n     (areset_n),
    .usb_reset_i  (usb_reset_i),
    .reset_no     (reset_no),
    .core_reset_o (core_reset)
  );

  telemetry_recorder #(
    .tele_depth   (tele_depth),
    .tele_max_pkt (tele_max_pkt)
  ) u_telemetry (
    .clock        (clock),
    .areset_n     (areset_n),
    .clear_i      (core_reset),
    .usb_sof_i    (usb_sof_i),
    .crc_err_i    (crc_err_i),
    .tele_start_i (tele_start),
    .level_o      (tele_level),
    .tele_o       (tele_stream.source)
  );

  in_stream_select #(
    .tele_endpoint (tele_endpoint),
    .level_w       (level_w)
  ) u_select (
    .clock           (clock),
    .areset_n        (areset_n),
    .clear_i         (core_reset),
    .blk_endpt_i     (blk_endpt_i),
    .blk_start_i     (blk_start_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .tele_level_i    (tele_level),
    .s_valid_i       (s_axis_tvalid_i),
    .s_last_i        (s_axis_tlast_i),
    .s_keep_i        (s_axis_tkeep_i),
    .s_data_i        (s_axis_tdata_i),
    .s_ready_o       (s_axis_tready_o),
    .tele_i          (tele_stream.sink),
    .mux_o           (mux_stream.source),
    .tele_start_o    (tele_start),
    .blk_in_ready_o  (blk_in_ready_o),
    .has_telemetry_o (has_telemetry_o)
  );

  axis_skid #(
    .payload_t (usb_in_pkg::in_beat_t)
  ) u_skid (
    .clock       (clock),
    .areset_n    (areset_n),
    .clear_i     (core_reset),
    .s_i         (mux_stream.sink),
    .m_valid_o   (m_axis_tvalid_o),
    .m_ready_i   (m_axis_tready_i),
    .m_last_o    (m_axis_tlast_o),
    .m_payload_o (m_beat)
  );

endmodule

//--- dv/bulk_in_props.sv
`timescale 1ns/1ps

module bulk_in_props #(
  parameter int tele_endpoint = usb_in_pkg::TELE_ENDPOINT_DEF
) (
  input logic               clock,
  input logic               areset_n,
  input logic               reset_no,
  input logic               usb_reset_o,
  input usb_in_pkg::endpt_t blk_endpt_i,
  input logic               s_axis_tready_o,
  input logic               m_axis_tvalid_o,
  input logic               m_axis_tready_i,
  input logic               m_axis_tlast_o,
  input logic               m_axis_tkeep_o,
  input usb_in_pkg::byte_t  m_axis_tdata_o
);

  // Beat on m_axis held until the sink takes it
  m_axis_hold: assert property (@(posedge clock) disable iff (!areset_n || usb_reset_o)
      m_axis_tvalid_o && !m_axis_tready_i |=> m_axis_tvalid_o && $stable(m_axis_tlast_o)
        && $stable(m_axis_tkeep_o) && $stable(m_axis_tdata_o))
    else $error("m_axis beat changed while tready was low");

  reset_order: assert property (@(posedge clock) !reset_no |-> usb_reset_o)
    else $error("usb_reset_o low while reset_no still low");

  // Select register follows the endpoint one cycle late
  user_blocked: assert property (@(posedge clock) disable iff (!areset_n)
      $past(blk_endpt_i) == usb_in_pkg::endpt_t'(tele_endpoint) && !$past(usb_reset_o)
        |-> !s_axis_tready_o)
    else $error("s_axis_tready_o high while telemetry endpoint selected");

endmodule

bind usb_bulk_in_top bulk_in_props #(
  .tele_endpoint (tele_endpoint)
) i_props (
  .clock           (clock),
  .areset_n        (areset_n),
  .reset_no        (reset_no),
  .usb_reset_o     (usb_reset_o),
  .blk_endpt_i     (blk_endpt_i),
  .s_axis_tready_o (s_axis_tready_o),
  .m_axis_tvalid_o (m_axis_tvalid_o),
  .m_axis_tready_i (m_axis_tready_i),
  .m_axis_tlast_o  (m_axis_tlast_o),
  .m_axis_tkeep_o  (m_axis_tkeep_o),
  .m_axis_tdata_o  (m_axis_tdata_o)
);

//--- dv/tb_usb_bulk_in.sv
`timescale 1ns/1ps

module tb_usb_bulk_in;

  localparam int rounds         = 4;
  localparam int user_cycles    = 150;
  localparam int planned_cycles = rounds * (user_cycles + 100) + 200;
  localparam usb_in_pkg::endpt_t tele_ep = usb_in_pkg::endpt_t'(usb_in_pkg::TELE_ENDPOINT_DEF);
  localparam usb_in_pkg::endpt_t user_ep = 4'd1;

  typedef struct packed {
    logic                 last;
    usb_in_pkg::in_beat_t beat;
  } exp_beat_t;

  logic               clock;
  logic               areset_n;
  logic               usb_reset_i;
  logic               usb_sof_i;
  logic               crc_err_i;
  logic               blk_start_i;
  logic               blk_in_ready_i;
  usb_in_pkg::endpt_t blk_endpt_i;
  logic               s_axis_tvalid_i;
  logic               s_axis_tlast_i;
  logic               s_axis_tkeep_i;
  usb_in_pkg::byte_t  s_axis_tdata_i;
  logic               s_axis_tready_o;
  logic               m_axis_tvalid_o;
  logic               m_axis_tlast_o;
  logic               m_axis_tkeep_o;
  usb_in_pkg::byte_t  m_axis_tdata_o;
  logic               m_axis_tready_i;
  logic               reset_no;
  logic               usb_reset_o;
  logic               blk_in_ready_o;
  logic               has_telemetry_o;

  logic [31:0]           seed = 32'h89f77afb;
  exp_beat_t             exp_q[$];      // Beats still due on m_axis
  usb_in_pkg::tele_rec_t fifo_model[$];
  logic [3:0]            sof_seq;
  logic [3:0]            crc_cnt;
  usb_in_pkg::in_beat_t  usr_beat;      // Held until s_axis takes it
  logic                  usr_last;
  logic                  usr_valid;
  logic                  tele_mode;
  int                    beat_count;

  usb_bulk_in_top i_dut (.*);

  always #4 clock = ~clock;

  initial begin
    repeat (20 * planned_cycles) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", 20 * planned_cycles);
    $display("CHECKS FAILED");
    $fatal(1, "Watchdog expired");
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 8) % n);
  endfunction

  task automatic fail_now(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic check_beat(input usb_in_pkg::byte_t exp_data, input logic exp_keep,
                            input logic exp_last);
    if (m_axis_tdata_o !== exp_data || m_axis_tkeep_o !== exp_keep ||
        m_axis_tlast_o !== exp_last) begin
      fail_now($sformatf("m_axis beat %02h keep %0b last %0b, expected %02h keep %0b last %0b",
                         m_axis_tdata_o, m_axis_tkeep_o, m_axis_tlast_o,
                         exp_data, exp_keep, exp_last));
    end else begin
      beat_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("%s is %0b, expected %0b", name, got, exp));
    end
  endtask

  task automatic check_level_flags();
    int level;
    level = fifo_model.size();
    check_flag("has_telemetry_o", has_telemetry_o, level >= usb_in_pkg::HAS_TELE_LEVEL);
    check_flag("blk_in_ready_o", blk_in_ready_o,
               blk_in_ready_i || (level >= usb_in_pkg::IN_READY_LEVEL));
  endtask

  // Drives at the falling edge and models the rising edge after it
  task automatic step(input int sof_div, input int crc_div, input bit user_on);
    logic                  sof;
    logic                  crc;
    logic [3:0]            cnt_next;
    usb_in_pkg::tele_rec_t rec;
    exp_beat_t             exp;
    sof = 1'b0;
    crc = 1'b0;
    m_axis_tready_i = (rand_below(10) < 7);
    if (sof_div > 0) sof = (rand_below(sof_div) == 0);
    if (crc_div > 0) crc = (rand_below(crc_div) == 0);
    if (user_on && !usr_valid && rand_below(3) != 0) begin
      usr_beat.data = usb_in_pkg::byte_t'(next_rand() >> 16);
      usr_beat.keep = (rand_below(8) != 0);
      usr_last      = (rand_below(6) == 0);
      usr_valid     = 1'b1;
    end
    usb_sof_i       = sof;
    crc_err_i       = crc;
    s_axis_tvalid_i = usr_valid;
    s_axis_tdata_i  = usr_beat.data;
    s_axis_tkeep_i  = usr_beat.keep;
    s_axis_tlast_i  = usr_last;

    if (tele_mode) check_flag("s_axis_tready_o", s_axis_tready_o, 1'b0);
    if (m_axis_tvalid_o && m_axis_tready_i) begin
      if (exp_q.size() == 0) begin
        fail_now($sformatf("unexpected beat %02h on m_axis", m_axis_tdata_o));
      end else begin
        exp = exp_q.pop_front();
        check_beat(exp.beat.data, exp.beat.keep, exp.last);
      end
    end
    if (usr_valid && s_axis_tready_o) begin
      exp.beat = usr_beat;
      exp.last = usr_last;
      exp_q.push_back(exp);
      usr_valid = 1'b0;
    end

    // A CRC error in the SOF cycle still counts for the closing frame
    cnt_next = crc_cnt;
    if (crc && crc_cnt != 4'hf) cnt_next = crc_cnt + 4'd1;
    if (sof) begin
      if (fifo_model.size() < usb_in_pkg::TELE_DEPTH_DEF) begin
        rec.seq      = sof_seq;
        rec.crc_errs = cnt_next;
        fifo_model.push_back(rec);
      end
      sof_seq = sof_seq + 4'd1;
      crc_cnt = 4'd0;
    end else begin
      crc_cnt = cnt_next;
    end
    @(negedge clock);
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || usr_valid) step(0, 0, 1'b0);
  endtask

  task automatic change_endpoint(input usb_in_pkg::endpt_t ep);
    tele_mode   = 1'b0;
    blk_endpt_i = ep;
    repeat (3) step(0, 0, 1'b0);
    tele_mode = (ep == tele_ep);
  endtask

  task automatic level_flag_check();
    blk_in_ready_i = (rand_below(2) != 0);
    repeat (2) step(0, 0, 1'b0);  // Quiet cycles
    check_level_flags();
  endtask

  task automatic read_telemetry();
    int                    n;
    int                    i;
    usb_in_pkg::tele_rec_t rec;
    exp_beat_t             exp;
    drain();
    change_endpoint(tele_ep);
    n = fifo_model.size();
    if (n > usb_in_pkg::TELE_MAX_PKT_DEF) n = usb_in_pkg::TELE_MAX_PKT_DEF;
    for (i = 0; i < n; i++) begin
      rec           = fifo_model.pop_front();
      exp.beat.data = usb_in_pkg::byte_t'(rec);
      exp.beat.keep = 1'b1;
      exp.last      = (i == n - 1);
      exp_q.push_back(exp);
    end
    blk_start_i = 1'b1;
    step(0, 0, 1'b1);
    blk_start_i = 1'b0;
    while (exp_q.size() != 0) step(0, 0, 1'b1);  // User beats offered but blocked
    repeat (2) step(0, 0, 1'b1);
    change_endpoint(user_ep);
    drain();
  endtask

  task automatic bus_reset_pulse(input int hold);
    usb_reset_i = 1'b1;
    repeat (hold) begin
      step(0, 0, 1'b0);
      check_flag("usb_reset_o", usb_reset_o, 1'b1);
    end
    usb_reset_i = 1'b0;
    step(0, 0, 1'b0);
    check_flag("usb_reset_o", usb_reset_o, 1'b1);
    step(0, 0, 1'b0);
    check_flag("usb_reset_o", usb_reset_o, 1'b0);
    check_flag("reset_no", reset_no, 1'b1);
    fifo_model.delete();  // Core clear empties the recorder
    sof_seq = 4'd0;
    crc_cnt = 4'd0;
  endtask

  initial begin
    int round;
    clock           = 1'b0;
    areset_n        = 1'b0;
    usb_reset_i     = 1'b0;
    usb_sof_i       = 1'b0;
    crc_err_i       = 1'b0;
    blk_start_i     = 1'b0;
    blk_in_ready_i  = 1'b0;
    blk_endpt_i     = user_ep;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    s_axis_tkeep_i  = 1'b0;
    s_axis_tdata_i  = '0;
    m_axis_tready_i = 1'b0;
    sof_seq         = 4'd0;
    crc_cnt         = 4'd0;
    usr_beat        = '0;
    usr_last        = 1'b0;
    usr_valid       = 1'b0;
    tele_mode       = 1'b0;
    beat_count      = 0;

    repeat (2) @(negedge clock);
    check_flag("reset_no", reset_no, 1'b0);
    check_flag("usb_reset_o", usb_reset_o, 1'b1);
    check_flag("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
    check_flag("has_telemetry_o", has_telemetry_o, 1'b0);
    check_flag("blk_in_ready_o", blk_in_ready_o, 1'b0);
    areset_n = 1'b1;
    for (int i = 1; i <= 4; i++) begin
      step(0, 0, 1'b0);
      check_flag("reset_no", reset_no, i >= 2);
      check_flag("usb_reset_o", usb_reset_o, i < 4);
    end

    for (round = 0; round < rounds; round++) begin
      // Sparse frames with dense errors first so the count saturates
      repeat (user_cycles) step(round == 0 ? 40 : 4, round == 0 ? 2 : 5, 1'b1);
      drain();
      level_flag_check();
      read_telemetry();
    end

    repeat (6) step(1, 3, 1'b0);
    level_flag_check();
    bus_reset_pulse(1 + rand_below(3));
    level_flag_check();
    repeat (3) step(1, 2, 1'b0);
    read_telemetry();

    $display("%0d beats checked on m_axis", beat_count);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- build.f
rtl/usb_in_pkg.sv
rtl/in_stream_if.sv
rtl/reset_sequencer.sv
rtl/tele_fifo.sv
rtl/telemetry_recorder.sv
rtl/in_stream_select.sv
rtl/axis_skid.sv
rtl/usb_bulk_in_top.sv
dv/bulk_in_props.sv
dv/tb_usb_bulk_in.sv

//--- run.sh
#!/bin/sh
# Build and run the bulk IN testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_usb_bulk_in -f build.f -o sim_tb_usb_bulk_in

./obj_dir/sim_tb_usb_bulk_in
